//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // architectural data word and register index
  typedef logic [15:0] data_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  func_t;

  // operation codes, anything above FUNC_MULH is rejected at issue
  localparam func_t FUNC_ADD  = 4'd0;
  localparam func_t FUNC_SUB  = 4'd1;
  localparam func_t FUNC_MUL  = 4'd2;
  localparam func_t FUNC_MULH = 4'd3;

  localparam int NUM_REGS = 16;

  // issue word layout inside pwdata
  localparam int FUNC_LSB = 12;
  localparam int RD_LSB   = 8;
  localparam int RS1_LSB  = 4;
  localparam int RS2_LSB  = 0;

  // apb address map
  localparam logic [7:0] ADDR_ISSUE    = 8'h00;
  localparam logic [7:0] ADDR_STATUS   = 8'h04;
  localparam logic [7:0] ADDR_REG_BASE = 8'h40;

endpackage

`default_nettype wire

//--- rtl/rs_pkg.sv
`default_nettype none

package rs_pkg;

  // a tag names one reservation station entry, zero means no producer
  typedef logic [2:0] tag_t;

  localparam tag_t TAG_NONE = 3'd0;

  // adder entries take tags 1..3, multiplier entries take tags 4..6
  localparam tag_t ADD_TAG_BASE = 3'd1;
  localparam tag_t MUL_TAG_BASE = 3'd4;

  localparam int NUM_ADD_RS = 3;
  localparam int NUM_MUL_RS = 3;

endpackage

`default_nettype wire

//--- rtl/apb_issue_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_issue_port (
  input  logic              clk2,
  input  logic              rst,
  input  logic [7:0]        paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              add_full,
  input  logic              mul_full,
  input  rs_pkg::tag_t      add_alloc_tag,
  input  rs_pkg::tag_t      mul_alloc_tag,
  input  isa_pkg::data_t    rs1_value,
  input  rs_pkg::tag_t      rs1_tag,
  input  isa_pkg::data_t    rs2_value,
  input  rs_pkg::tag_t      rs2_tag,
  input  isa_pkg::data_t    reg_rd_value,
  input  rs_pkg::tag_t      reg_rd_tag,
  input  logic              core_busy,
  output logic              add_alloc,
  output logic              mul_alloc,
  output isa_pkg::func_t    alloc_func,
  output isa_pkg::data_t    op_a,
  output isa_pkg::data_t    op_b,
  output rs_pkg::tag_t      tag_a,
  output rs_pkg::tag_t      tag_b,
  output isa_pkg::reg_idx_t rs1_idx,
  output isa_pkg::reg_idx_t rs2_idx,
  output logic              rename_en,
  output isa_pkg::reg_idx_t rename_idx,
  output rs_pkg::tag_t      rename_tag,
  output logic              reg_wr_en,
  output isa_pkg::reg_idx_t reg_wr_idx,
  output isa_pkg::data_t    reg_wr_data,
  output isa_pkg::reg_idx_t reg_rd_idx
);
  import isa_pkg::*;
  import rs_pkg::*;

  logic  access;
  logic  setup;
  logic  is_issue;
  logic  is_status;
  logic  is_reg;
  func_t func;
  logic  func_ok;
  logic  is_mul;
  logic  issue_wr;
  logic  stall;
  logic  reg_pending;
  logic  rd_err_q;
  logic  wr_err;
  logic  op_err;

  // apb phases
  assign setup  = psel && !penable;
  assign access = psel && penable;

  // address decode, registers sit at base + 4 * index
  assign is_issue  = (paddr == ADDR_ISSUE);
  assign is_status = (paddr == ADDR_STATUS);
  assign is_reg    = (paddr[7:6] == ADDR_REG_BASE[7:6]) && (paddr[1:0] == 2'b00);

  // issue word fields
  assign func    = pwdata[FUNC_LSB +: $bits(func_t)];
  assign rs1_idx = pwdata[RS1_LSB +: $bits(reg_idx_t)];
  assign rs2_idx = pwdata[RS2_LSB +: $bits(reg_idx_t)];
  assign func_ok = (func <= FUNC_MULH);
  // mul and mulh go to the multiplier station
  assign is_mul  = (func == FUNC_MUL) || (func == FUNC_MULH);

  assign issue_wr = access && pwrite && is_issue;
  // back-pressure while the chosen station has no free entry
  assign stall    = issue_wr && func_ok && (is_mul ? mul_full : add_full);
  assign pready   = !stall;

  assign reg_rd_idx  = paddr[5:2];
  assign reg_pending = (reg_rd_tag != TAG_NONE);

  // error cases, each one blocks the access
  assign op_err  = issue_wr && !func_ok;
  assign wr_err  = access && pwrite && is_reg && reg_pending;
  assign pslverr = access && pready && (op_err || wr_err || (!pwrite && rd_err_q));

  // allocation in the completing cycle only
  assign add_alloc  = issue_wr && func_ok && !is_mul && !add_full;
  assign mul_alloc  = issue_wr && func_ok && is_mul && !mul_full;
  assign alloc_func = func;
  assign op_a       = rs1_value;
  assign op_b       = rs2_value;
  assign tag_a      = rs1_tag;
  assign tag_b      = rs2_tag;

  // destination takes the tag of the entry just allocated
  assign rename_en  = add_alloc || mul_alloc;
  assign rename_idx = pwdata[RD_LSB +: $bits(reg_idx_t)];
  assign rename_tag = is_mul ? mul_alloc_tag : add_alloc_tag;

  // direct register write, only when nothing is pending on it
  assign reg_wr_en   = access && pwrite && is_reg && !reg_pending;
  assign reg_wr_idx  = paddr[5:2];
  assign reg_wr_data = pwdata[$bits(data_t)-1:0];

  // read data and the pending flag are sampled together in the setup phase
  // so the access phase sees one consistent snapshot
  always_ff @(posedge clk2)
  begin
    if (rst)
    begin
      prdata   <= '0;
      rd_err_q <= 1'b0;
    end
    else if (setup)
    begin
      rd_err_q <= !pwrite && is_reg && reg_pending;
      if (pwrite)
        prdata <= '0;
      else if (is_status)
        prdata <= {31'd0, core_busy};
      else if (is_reg)
        prdata <= {{(32-$bits(data_t)){1'b0}}, reg_rd_value};
      else
        prdata <= '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/reg_status_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_file (
  input  logic              clk2,
  input  logic              rst,
  input  isa_pkg::reg_idx_t rs1_idx,
  input  isa_pkg::reg_idx_t rs2_idx,
  input  logic              rename_en,
  input  isa_pkg::reg_idx_t rename_idx,
  input  rs_pkg::tag_t      rename_tag,
  input  logic              reg_wr_en,
  input  isa_pkg::reg_idx_t reg_wr_idx,
  input  isa_pkg::data_t    reg_wr_data,
  input  isa_pkg::reg_idx_t reg_rd_idx,
  input  logic              cdb_valid,
  input  rs_pkg::tag_t      cdb_tag,
  input  isa_pkg::data_t    cdb_value,
  output isa_pkg::data_t    rs1_value,
  output rs_pkg::tag_t      rs1_tag,
  output isa_pkg::data_t    rs2_value,
  output rs_pkg::tag_t      rs2_tag,
  output isa_pkg::data_t    reg_rd_value,
  output rs_pkg::tag_t      reg_rd_tag
);
  import isa_pkg::*;
  import rs_pkg::*;

  // value and producer tag per architectural register
  data_t values [NUM_REGS];
  tag_t  tags   [NUM_REGS];

  logic  hit1;
  logic  hit2;

  // true when the producer of this register broadcasts right now
  function automatic logic cdb_hit(input tag_t t);
    return cdb_valid && (t != TAG_NONE) && (t == cdb_tag);
  endfunction

  // operand lookup, a same-cycle broadcast is forwarded as a present value
  assign hit1      = cdb_hit(tags[rs1_idx]);
  assign hit2      = cdb_hit(tags[rs2_idx]);
  assign rs1_value = hit1 ? cdb_value : values[rs1_idx];
  assign rs1_tag   = hit1 ? TAG_NONE : tags[rs1_idx];
  assign rs2_value = hit2 ? cdb_value : values[rs2_idx];
  assign rs2_tag   = hit2 ? TAG_NONE : tags[rs2_idx];

  // host port, no bypass because the host reads only when idle
  assign reg_rd_value = values[reg_rd_idx];
  assign reg_rd_tag   = tags[reg_rd_idx];

  always_ff @(posedge clk2)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        values[i] <= '0;
        tags[i]   <= TAG_NONE;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        // writeback only if this register still waits for that tag
        if (cdb_hit(tags[i]))
        begin
          values[i] <= cdb_value;
          tags[i]   <= TAG_NONE;
        end
        // host write, port already checked the tag is clear
        if (reg_wr_en && (reg_wr_idx == reg_idx_t'(i)))
          values[i] <= reg_wr_data;
        // rename is last so it wins over a same-cycle writeback
        if (rename_en && (rename_idx == reg_idx_t'(i)))
          tags[i] <= rename_tag;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
  parameter int           NUM_ENTRIES = rs_pkg::NUM_ADD_RS,
  parameter rs_pkg::tag_t TAG_BASE    = rs_pkg::ADD_TAG_BASE
) (
  input  logic           clk2,
  input  logic           rst,
  input  logic           alloc,
  input  isa_pkg::func_t alloc_func,
  input  isa_pkg::data_t op_a,
  input  isa_pkg::data_t op_b,
  input  rs_pkg::tag_t   tag_a,
  input  rs_pkg::tag_t   tag_b,
  input  logic           cdb_valid,
  input  rs_pkg::tag_t   cdb_tag,
  input  isa_pkg::data_t cdb_value,
  input  logic           unit_ready,
  output logic           full,
  output rs_pkg::tag_t   alloc_tag,
  output logic           issue_valid,
  output isa_pkg::func_t issue_func,
  output isa_pkg::data_t issue_a,
  output isa_pkg::data_t issue_b,
  output rs_pkg::tag_t   issue_tag,
  output logic           not_empty
);
  import isa_pkg::*;
  import rs_pkg::*;

  localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  // control per entry
  logic [NUM_ENTRIES-1:0] busy;
  logic [NUM_ENTRIES-1:0] issued;
  logic [NUM_ENTRIES-1:0] ready;

  // payload per entry, a slot holds a value once its tag is TAG_NONE
  func_t ent_func  [NUM_ENTRIES];
  data_t ent_a_val [NUM_ENTRIES];
  data_t ent_b_val [NUM_ENTRIES];
  tag_t  ent_a_tag [NUM_ENTRIES];
  tag_t  ent_b_tag [NUM_ENTRIES];

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             do_alloc;
  logic             do_issue;

  function automatic tag_t entry_tag(input int idx);
    return TAG_BASE + tag_t'(idx);
  endfunction

  // downward scans leave the lowest index selected
  always_comb
  begin
    free_idx = '0;
    sel_idx  = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--)
    begin
      ready[i] = busy[i] && !issued[i] && (ent_a_tag[i] == TAG_NONE) &&
                 (ent_b_tag[i] == TAG_NONE);
      if (!busy[i])
        free_idx = IDX_W'(i);
      if (ready[i])
        sel_idx = IDX_W'(i);
    end
  end

  assign full      = &busy;
  assign not_empty = |busy;
  assign alloc_tag = entry_tag(int'(free_idx));
  assign do_alloc  = alloc && !full;

  // dispatch port
  assign issue_valid = |ready;
  assign issue_func  = ent_func[sel_idx];
  assign issue_a     = ent_a_val[sel_idx];
  assign issue_b     = ent_b_val[sel_idx];
  assign issue_tag   = entry_tag(int'(sel_idx));
  assign do_issue    = issue_valid && unit_ready;

  // an entry stays allocated until its own tag is broadcast,
  // so its tag cannot be handed out again while the result is in flight
  always_ff @(posedge clk2)
  begin
    if (rst)
    begin
      busy   <= '0;
      issued <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
        if (busy[i] && issued[i] && cdb_valid && (cdb_tag == entry_tag(i)))
        begin
          busy[i]   <= 1'b0;
          issued[i] <= 1'b0;
        end
        if (do_issue && (sel_idx == IDX_W'(i)))
          issued[i] <= 1'b1;
        if (do_alloc && (free_idx == IDX_W'(i)))
        begin
          busy[i]   <= 1'b1;
          issued[i] <= 1'b0;
        end
      end
    end
  end

  // operand capture, from the cdb by tag or from the issue port
  always_ff @(posedge clk2)
  begin
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      if (cdb_valid && (ent_a_tag[i] == cdb_tag))
      begin
        ent_a_val[i] <= cdb_value;
        ent_a_tag[i] <= TAG_NONE;
      end
      if (cdb_valid && (ent_b_tag[i] == cdb_tag))
      begin
        ent_b_val[i] <= cdb_value;
        ent_b_tag[i] <= TAG_NONE;
      end
      if (do_alloc && (free_idx == IDX_W'(i)))
      begin
        ent_func[i]  <= alloc_func;
        ent_a_val[i] <= op_a;
        ent_b_val[i] <= op_b;
        ent_a_tag[i] <= tag_a;
        ent_b_tag[i] <= tag_b;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic           clk2,
  input  logic           rst,
  input  logic           issue_valid,
  input  isa_pkg::func_t issue_func,
  input  isa_pkg::data_t issue_a,
  input  isa_pkg::data_t issue_b,
  input  rs_pkg::tag_t   issue_tag,
  input  logic           cdb_gnt,
  output logic           unit_ready,
  output logic           cdb_req,
  output rs_pkg::tag_t   req_tag,
  output isa_pkg::data_t req_value
);
  import isa_pkg::*;

  logic hold_valid;
  logic accept;

  // the holding register frees up in the cycle it is granted
  assign unit_ready = !hold_valid || cdb_gnt;
  assign accept     = issue_valid && unit_ready;
  assign cdb_req    = hold_valid;

  always_ff @(posedge clk2)
  begin
    if (rst)
      hold_valid <= 1'b0;
    else if (accept)
      hold_valid <= 1'b1;
    else if (cdb_gnt)
      hold_valid <= 1'b0;
  end

  // only add and sub reach this unit
  always_ff @(posedge clk2)
  begin
    if (accept)
    begin
      req_tag   <= issue_tag;
      req_value <= (issue_func == FUNC_SUB) ? issue_a - issue_b : issue_a + issue_b;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  logic           clk2,
  input  logic           rst,
  input  logic           issue_valid,
  input  isa_pkg::func_t issue_func,
  input  isa_pkg::data_t issue_a,
  input  isa_pkg::data_t issue_b,
  input  rs_pkg::tag_t   issue_tag,
  input  logic           cdb_gnt,
  output logic           unit_ready,
  output logic           cdb_req,
  output rs_pkg::tag_t   req_tag,
  output isa_pkg::data_t req_value
);
  import isa_pkg::*;
  import rs_pkg::*;

  localparam int DW = $bits(data_t);

  // stage one and two carry the full product and the high-half select
  logic          s1_valid;
  logic          s2_valid;
  logic          s3_valid;
  tag_t          s1_tag;
  tag_t          s2_tag;
  logic          s1_high;
  logic          s2_high;
  logic [2*DW-1:0] s1_prod;
  logic [2*DW-1:0] s2_prod;
  logic          advance;

  // the whole pipe moves only when the last stage drains
  assign advance    = !s3_valid || cdb_gnt;
  assign unit_ready = advance;
  assign cdb_req    = s3_valid;

  always_ff @(posedge clk2)
  begin
    if (rst)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end
    else if (advance)
    begin
      s1_valid <= issue_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk2)
  begin
    if (advance)
    begin
      // unsigned product, mulh keeps the upper half
      s1_prod   <= issue_a * issue_b;
      s1_high   <= (issue_func == FUNC_MULH);
      s1_tag    <= issue_tag;
      s2_prod   <= s1_prod;
      s2_high   <= s1_high;
      s2_tag    <= s1_tag;
      req_value <= s2_high ? s2_prod[2*DW-1:DW] : s2_prod[DW-1:0];
      req_tag   <= s2_tag;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  logic           clk2,
  input  logic           rst,
  input  logic           alu_req,
  input  rs_pkg::tag_t   alu_tag,
  input  isa_pkg::data_t alu_value,
  input  logic           mul_req,
  input  rs_pkg::tag_t   mul_tag,
  input  isa_pkg::data_t mul_value,
  output logic           alu_gnt,
  output logic           mul_gnt,
  output logic           cdb_valid,
  output rs_pkg::tag_t   cdb_tag,
  output isa_pkg::data_t cdb_value
);

  // set when the multiplier took the bus last
  logic last_mul;

  // on contention the unit that lost last time goes first
  assign mul_gnt = mul_req && (!alu_req || !last_mul);
  assign alu_gnt = alu_req && !mul_gnt;

  assign cdb_valid = alu_req || mul_req;
  assign cdb_tag   = mul_gnt ? mul_tag : alu_tag;
  assign cdb_value = mul_gnt ? mul_value : alu_value;

  always_ff @(posedge clk2)
  begin
    if (rst)
      last_mul <= 1'b0;
    else if (cdb_valid)
      last_mul <= mul_gnt;
  end

endmodule

`default_nettype wire

//--- rtl/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core (
  input  logic        clk2,
  input  logic        rst,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import isa_pkg::*;
  import rs_pkg::*;

  // issue path
  logic     add_alloc;
  logic     mul_alloc;
  func_t    alloc_func;
  data_t    op_a;
  data_t    op_b;
  tag_t     tag_a;
  tag_t     tag_b;
  logic     add_full;
  logic     mul_full;
  tag_t     add_alloc_tag;
  tag_t     mul_alloc_tag;

  // register file lookups and updates
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  data_t    rs1_value;
  data_t    rs2_value;
  tag_t     rs1_tag;
  tag_t     rs2_tag;
  logic     rename_en;
  reg_idx_t rename_idx;
  tag_t     rename_tag;
  logic     reg_wr_en;
  reg_idx_t reg_wr_idx;
  data_t    reg_wr_data;
  reg_idx_t reg_rd_idx;
  data_t    reg_rd_value;
  tag_t     reg_rd_tag;

  // dispatch, station to unit
  logic     add_issue_valid;
  func_t    add_issue_func;
  data_t    add_issue_a;
  data_t    add_issue_b;
  tag_t     add_issue_tag;
  logic     alu_ready;
  logic     add_not_empty;
  logic     mul_issue_valid;
  func_t    mul_issue_func;
  data_t    mul_issue_a;
  data_t    mul_issue_b;
  tag_t     mul_issue_tag;
  logic     mul_ready;
  logic     mul_not_empty;

  // result bus
  logic     alu_req;
  logic     alu_gnt;
  tag_t     alu_tag;
  data_t    alu_value;
  logic     mul_req;
  logic     mul_gnt;
  tag_t     mul_tag;
  data_t    mul_value;
  logic     cdb_valid;
  tag_t     cdb_tag;
  data_t    cdb_value;
  logic     core_busy;

  // idle means no entry held and no result waiting for the bus
  assign core_busy = add_not_empty || mul_not_empty || alu_req || mul_req;

  apb_issue_port u_apb (
    .clk2, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .add_full, .mul_full, .add_alloc_tag, .mul_alloc_tag,
    .rs1_value, .rs1_tag, .rs2_value, .rs2_tag, .reg_rd_value, .reg_rd_tag, .core_busy,
    .add_alloc, .mul_alloc, .alloc_func, .op_a, .op_b, .tag_a, .tag_b,
    .rs1_idx, .rs2_idx, .rename_en, .rename_idx, .rename_tag,
    .reg_wr_en, .reg_wr_idx, .reg_wr_data, .reg_rd_idx
  );

  reg_status_file u_regs (
    .clk2, .rst, .rs1_idx, .rs2_idx, .rename_en, .rename_idx, .rename_tag,
    .reg_wr_en, .reg_wr_idx, .reg_wr_data, .reg_rd_idx,
    .cdb_valid, .cdb_tag, .cdb_value,
    .rs1_value, .rs1_tag, .rs2_value, .rs2_tag, .reg_rd_value, .reg_rd_tag
  );

  reservation_station #(.NUM_ENTRIES(NUM_ADD_RS), .TAG_BASE(ADD_TAG_BASE)) add_rs (
    .clk2, .rst, .alloc(add_alloc), .alloc_func, .op_a, .op_b, .tag_a, .tag_b,
    .cdb_valid, .cdb_tag, .cdb_value, .unit_ready(alu_ready),
    .full(add_full), .alloc_tag(add_alloc_tag), .issue_valid(add_issue_valid),
    .issue_func(add_issue_func), .issue_a(add_issue_a), .issue_b(add_issue_b),
    .issue_tag(add_issue_tag), .not_empty(add_not_empty)
  );

  reservation_station #(.NUM_ENTRIES(NUM_MUL_RS), .TAG_BASE(MUL_TAG_BASE)) mul_rs (
    .clk2, .rst, .alloc(mul_alloc), .alloc_func, .op_a, .op_b, .tag_a, .tag_b,
    .cdb_valid, .cdb_tag, .cdb_value, .unit_ready(mul_ready),
    .full(mul_full), .alloc_tag(mul_alloc_tag), .issue_valid(mul_issue_valid),
    .issue_func(mul_issue_func), .issue_a(mul_issue_a), .issue_b(mul_issue_b),
    .issue_tag(mul_issue_tag), .not_empty(mul_not_empty)
  );

  alu_unit u_alu (
    .clk2, .rst, .issue_valid(add_issue_valid), .issue_func(add_issue_func),
    .issue_a(add_issue_a), .issue_b(add_issue_b), .issue_tag(add_issue_tag),
    .cdb_gnt(alu_gnt), .unit_ready(alu_ready), .cdb_req(alu_req),
    .req_tag(alu_tag), .req_value(alu_value)
  );

  mul_unit u_mul (
    .clk2, .rst, .issue_valid(mul_issue_valid), .issue_func(mul_issue_func),
    .issue_a(mul_issue_a), .issue_b(mul_issue_b), .issue_tag(mul_issue_tag),
    .cdb_gnt(mul_gnt), .unit_ready(mul_ready), .cdb_req(mul_req),
    .req_tag(mul_tag), .req_value(mul_value)
  );

  cdb_arbiter u_arb (
    .clk2, .rst, .alu_req, .alu_tag, .alu_value, .mul_req, .mul_tag, .mul_value,
    .alu_gnt, .mul_gnt, .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

`default_nettype wire

//--- testbench/tomasulo_props.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_props (
  input logic         clk2,
  input logic         rst,
  input logic [7:0]   paddr,
  input logic         psel,
  input logic         penable,
  input logic         pwrite,
  input logic         pready,
  input logic         pslverr,
  input logic         alu_req,
  input logic         mul_req,
  input logic         alu_gnt,
  input logic         mul_gnt,
  input logic         cdb_valid,
  input rs_pkg::tag_t cdb_tag
);
  import isa_pkg::*;
  import rs_pkg::*;

  // failure count read by the testbench top at the end
  int fail_count = 0;

  // at most one unit owns the result bus and the owner alternates under contention
  grant_onehot: assert property (@(posedge clk2) disable iff (rst)
    !(alu_gnt && mul_gnt) &&
    (!(alu_req && mul_req && $past(alu_req && mul_req)) || (mul_gnt != $past(mul_gnt))))
  else
  begin
    fail_count++;
    $error("cdb grants overlap or do not alternate between contending units");
  end

  // a broadcast always names a station entry
  cdb_tag_named: assert property (@(posedge clk2) disable iff (rst)
    cdb_valid |-> (cdb_tag != TAG_NONE))
  else
  begin
    fail_count++;
    $error("cdb valid with an empty tag");
  end

  // error response only on a completing transfer
  // register and status accesses finish in their first access cycle
  slverr_with_ready: assert property (@(posedge clk2) disable iff (rst)
    (!pslverr || pready) &&
    (!(psel && penable && !(pwrite && (paddr == ADDR_ISSUE))) || pready))
  else
  begin
    fail_count++;
    $error("pslverr without pready, or a register or status access held waiting");
  end

  // no grant without a request, and an ungranted request stays up
  grant_needs_req: assert property (@(posedge clk2) disable iff (rst)
    (!alu_gnt || alu_req) && (!mul_gnt || mul_req) &&
    (!$past(alu_req && !alu_gnt) || alu_req) && (!$past(mul_req && !mul_gnt) || mul_req))
  else
  begin
    fail_count++;
    $error("cdb grant without a request, or a waiting request dropped before its grant");
  end

endmodule

bind tomasulo_core tomasulo_props i_props (
  .clk2, .rst, .paddr, .psel, .penable, .pwrite, .pready, .pslverr,
  .alu_req, .mul_req, .alu_gnt, .mul_gnt, .cdb_valid, .cdb_tag
);

`default_nettype wire

//--- testbench/tomasulo_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_checker (
  input  logic        clk2,
  input  logic        rst,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  input  logic [31:0] prdata,
  input  logic        pready,
  input  logic        pslverr,
  output int          mismatch_count,
  output int          check_count,
  output int          stall_cycles
);
  import isa_pkg::*;

  // in-order model of the architectural registers
  data_t               model [NUM_REGS];
  // destinations issued since the core was last seen idle
  logic [NUM_REGS-1:0] maybe_pending;
  logic                issued_any;
  int                  cycle_no;
  int                  last_issue_cycle;
  reg_idx_t            last_rd;

  // sequential result of one instruction
  function automatic data_t ref_result(input func_t func, input data_t a, input data_t b);
    logic [31:0] prod;
    prod = {16'h0, a} * {16'h0, b};
    case (func)
      FUNC_ADD: return a + b;
      FUNC_SUB: return a - b;
      FUNC_MUL: return prod[15:0];
      default:  return prod[31:16];
    endcase
  endfunction

  task automatic check_err(input logic [7:0] addr, input logic exp, input logic got);
    check_count++;
    if (exp !== got)
    begin
      mismatch_count++;
      $display("mismatch pslverr addr %h exp %h got %h", addr, exp, got);
    end
  endtask

  // sampled mid-cycle, a transfer seen here completes at the next rising edge
  always @(negedge clk2)
  begin
    reg_idx_t idx;
    reg_idx_t rd;
    func_t    func;
    logic     is_reg;
    logic     just_renamed;
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        model[i] = '0;
      maybe_pending    = '0;
      issued_any       = 1'b0;
      cycle_no         = 0;
      last_issue_cycle = -10;
      last_rd          = '0;
      mismatch_count   = 0;
      check_count      = 0;
      stall_cycles     = 0;
    end
    else
    begin
      cycle_no++;
      if (psel && penable && !pready)
        stall_cycles++;
      if (psel && penable && pready)
      begin
        idx    = paddr[5:2];
        is_reg = (paddr >= ADDR_REG_BASE) && (paddr < ADDR_REG_BASE + 8'(4 * NUM_REGS)) &&
                 (paddr[1:0] == 2'b00);
        // destination of the issue just before, no result can be back yet
        just_renamed = issued_any && (cycle_no == last_issue_cycle + 2) && (idx == last_rd);
        if (pwrite && (paddr == ADDR_ISSUE))
        begin
          func = pwdata[FUNC_LSB +: 4];
          rd   = pwdata[RD_LSB +: 4];
          check_err(paddr, func > FUNC_MULH, pslverr);
          if (!pslverr && (func <= FUNC_MULH))
          begin
            model[rd] = ref_result(func, model[pwdata[RS1_LSB +: 4]],
                                   model[pwdata[RS2_LSB +: 4]]);
            maybe_pending[rd] = 1'b1;
            issued_any        = 1'b1;
            last_issue_cycle  = cycle_no;
            last_rd           = rd;
          end
        end
        else if (!pwrite && (paddr == ADDR_STATUS))
        begin
          check_count++;
          if (!issued_any && (prdata != 32'h0))
          begin
            mismatch_count++;
            $display("mismatch prdata status exp 00000000 got %h", prdata);
          end
          // idle core, every tag is clear
          if (!prdata[0])
            maybe_pending = '0;
        end
        else if (is_reg)
        begin
          // error outcome known only when the tag state is certain
          if (just_renamed)
            check_err(paddr, 1'b1, pslverr);
          else if (!maybe_pending[idx])
            check_err(paddr, 1'b0, pslverr);
          if (!pslverr && pwrite)
          begin
            model[idx]         = pwdata[15:0];
            maybe_pending[idx] = 1'b0;
          end
          else if (!pslverr)
          begin
            check_count++;
            if (prdata != {16'h0, model[idx]})
            begin
              mismatch_count++;
              $display("mismatch prdata reg %h exp %h got %h", idx, model[idx], prdata);
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_tomasulo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo;
  import isa_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RAND_INSNS = 200;
  // directed part, then per random insn one issue, status polls and a full read-back
  localparam int NUM_OPS         = 200 + NUM_REGS + RAND_INSNS * (1 + 6 + NUM_REGS);
  localparam int WATCHDOG_CYCLES = NUM_OPS * 40;

  logic        clk2;
  logic        rst;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          mismatch_count;
  int          check_count;
  int          stall_cycles;

  tomasulo_core i_dut (
    .clk2, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  tomasulo_checker i_check (
    .clk2, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .mismatch_count, .check_count, .stall_cycles
  );

  initial
  begin
    clk2 = 1'b0;
    forever #(CLK_PERIOD / 2) clk2 = ~clk2;
  end

  // hard stop if the bus or the core hangs
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, the core stopped completing transfers",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // one apb transfer, entered and left 1 ns after a rising edge
  task automatic bus_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk2);
    #1;
    penable = 1'b1;
    // pready settled by mid-cycle
    @(negedge clk2);
    while (!pready)
      @(negedge clk2);
    rdata = prdata;
    @(posedge clk2);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic logic [7:0] reg_addr(input reg_idx_t idx);
    return ADDR_REG_BASE | {2'b00, idx, 2'b00};
  endfunction

  task automatic write_reg(input reg_idx_t idx, input data_t value);
    logic [31:0] rdata;
    bus_access(1'b1, reg_addr(idx), {16'h0, value}, rdata);
  endtask

  task automatic read_reg(input reg_idx_t idx);
    logic [31:0] rdata;
    bus_access(1'b0, reg_addr(idx), 32'h0, rdata);
  endtask

  task automatic issue_op(input func_t func, input reg_idx_t rd, input reg_idx_t rs1,
                          input reg_idx_t rs2);
    logic [31:0] rdata;
    bus_access(1'b1, ADDR_ISSUE, {16'h0, func, rd, rs1, rs2}, rdata);
  endtask

  // poll the busy bit until the core drains
  task automatic wait_idle();
    logic [31:0] status;
    status = 32'h1;
    while (status[0])
      bus_access(1'b0, ADDR_STATUS, 32'h0, status);
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < NUM_REGS; i++)
      read_reg(reg_idx_t'(i));
  endtask

  initial
  begin
    logic [31:0] rdata;
    int          total_errors;
    rst     = 1'b1;
    paddr   = 8'h0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'h0;
    void'($urandom(32'hac8c_d411));
    repeat (2) @(posedge clk2);
    #1;
    rst = 1'b0;

    // status after reset, then plain register traffic
    bus_access(1'b0, ADDR_STATUS, 32'h0, rdata);
    for (int i = 0; i < NUM_REGS; i++)
      write_reg(reg_idx_t'(i), 16'ha5c3 ^ (16'(i) * 16'h1111));
    read_all_regs();
    write_reg(4'd3, 16'hffff);
    write_reg(4'd2, 16'h8001);

    // one of each operation, no dependences
    issue_op(FUNC_ADD, 4'd4, 4'd1, 4'd2);
    issue_op(FUNC_SUB, 4'd5, 4'd1, 4'd2);
    issue_op(FUNC_MUL, 4'd6, 4'd1, 4'd2);
    issue_op(FUNC_MULH, 4'd7, 4'd3, 4'd3);
    wait_idle();
    read_all_regs();

    // raw chain across both stations, r8 and r9 written more than once
    issue_op(FUNC_ADD, 4'd8, 4'd1, 4'd2);
    issue_op(FUNC_MUL, 4'd9, 4'd8, 4'd3);
    issue_op(FUNC_SUB, 4'd10, 4'd9, 4'd8);
    issue_op(FUNC_ADD, 4'd8, 4'd10, 4'd1);
    issue_op(FUNC_MULH, 4'd8, 4'd2, 4'd9);
    issue_op(FUNC_ADD, 4'd9, 4'd8, 4'd8);
    wait_idle();
    read_all_regs();

    // five multiplies hanging off r13, the fifth meets a full station
    issue_op(FUNC_MUL, 4'd13, 4'd1, 4'd2);
    issue_op(FUNC_MUL, 4'd14, 4'd13, 4'd3);
    issue_op(FUNC_MULH, 4'd15, 4'd13, 4'd13);
    issue_op(FUNC_MUL, 4'd12, 4'd13, 4'd2);
    issue_op(FUNC_MULH, 4'd11, 4'd14, 4'd15);
    wait_idle();
    read_all_regs();

    // bad opcode, then read and write of a freshly renamed register
    issue_op(4'hf, 4'd1, 4'd2, 4'd3);
    issue_op(FUNC_MULH, 4'd11, 4'd3, 4'd2);
    read_reg(4'd11);
    issue_op(FUNC_MUL, 4'd12, 4'd11, 4'd3);
    write_reg(4'd12, 16'h1234);
    wait_idle();
    read_all_regs();

    // random registers and instructions
    for (int i = 0; i < NUM_REGS; i++)
      write_reg(reg_idx_t'(i), data_t'($urandom));
    for (int n = 0; n < RAND_INSNS; n++)
    begin
      issue_op(func_t'($urandom_range(3, 0)), reg_idx_t'($urandom_range(15, 0)),
               reg_idx_t'($urandom_range(15, 0)), reg_idx_t'($urandom_range(15, 0)));
      wait_idle();
      read_all_regs();
    end

    total_errors = mismatch_count + i_dut.i_props.fail_count;
    if (stall_cycles == 0)
    begin
      $display("issue back-pressure never seen on a full multiplier station");
      total_errors++;
    end
    $display("checks %0d, mismatches %0d, assertion failures %0d, stall cycles %0d",
             check_count, mismatch_count, i_dut.i_props.fail_count, stall_cycles);
    if (total_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/isa_pkg.sv
rtl/rs_pkg.sv
rtl/apb_issue_port.sv
rtl/reg_status_file.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_arbiter.sv
rtl/tomasulo_core.sv
testbench/tomasulo_props.sv
testbench/tomasulo_checker.sv
testbench/tb_tomasulo.sv

//--- Makefile
# Verilator build and run of the Tomasulo core testbench

VERILATOR ?= verilator
TOP       ?= tb_tomasulo
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
